// ==== cpu_pkg.sv ====
package cpu_pkg;

    localparam logic [31:0] reset_vector = 32'hbfc00000;

    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_regimm  = 6'b000001;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_blez    = 6'b000110;
    localparam logic [5:0] op_bgtz    = 6'b000111;
    localparam logic [5:0] op_addi    = 6'b001000;  // First of the I-type ALU group
    localparam logic [5:0] op_lui     = 6'b001111;  // Last of the I-type ALU group
    localparam logic [5:0] op_cop0    = 6'b010000;

    localparam logic [5:0] funct_jr   = 6'b001000;
    localparam logic [5:0] funct_jalr = 6'b001001;
    localparam logic [5:0] funct_eret = 6'b011000;
    localparam logic [4:0] cop0_co    = 5'b10000;   // CO bit in the rs field

    localparam logic [4:0] rt_bltz    = 5'b00000;
    localparam logic [4:0] rt_bgez    = 5'b00001;
    localparam logic [4:0] rt_bltzal  = 5'b10000;
    localparam logic [4:0] rt_bgezal  = 5'b10001;

    localparam logic [2:0] br_beq     = 3'd0;
    localparam logic [2:0] br_bne     = 3'd1;
    localparam logic [2:0] br_bgez    = 3'd2;
    localparam logic [2:0] br_bgtz    = 3'd3;
    localparam logic [2:0] br_blez    = 3'd4;
    localparam logic [2:0] br_bltz    = 3'd5;
    localparam logic [2:0] br_bgezal  = 3'd6;
    localparam logic [2:0] br_bltzal  = 3'd7;

    localparam int jump_reg  = 0;  // Target from rs
    localparam int jump_link = 1;  // Writes the return address

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_format;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_format;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index;
    } j_format;

    typedef union packed {
        r_format r_fmt;
        i_format i_fmt;
        j_format j_fmt;
    } instr_word;

    typedef struct packed {
        logic       isbranch;
        logic [2:0] branch;
        logic       isjump;
        logic [1:0] jump;
        logic       regwrite;
        logic       eret;
        logic       is_instr;
    } ctrl_reg;

    typedef struct packed {
        logic equal;
        logic e0;
        logic g0;
    } branch_rel;

    typedef struct packed {
        instr_word   instr;
        logic [31:0] pc;
        logic [31:0] pcplus4;
        logic        in_delay_slot;
        logic        is_instr;
        logic        addr_err_if;
    } dp_ftod;

    typedef struct packed {
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        logic [2:0]  cp0_sel;
        logic [31:0] rsdata;
        logic [31:0] rtdata;
        logic [31:0] pc;
        logic        in_delay_slot;
        logic        addr_err_if;
        logic        is_instr;
        ctrl_reg     ctrl;
    } dp_dtoe;

endpackage

// ==== pc_fetch.sv ====
`timescale 1ns/10ps

module pc_fetch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               is_valid_exc,
    input  logic [31:0]        next_pc,
    input  cpu_pkg::instr_word imem_rdata,
    input  logic               in_delay_slot,
    output logic [31:0]        imem_addr,
    output logic [31:0]        pcplus4,
    output cpu_pkg::dp_ftod    ftod
);
    import cpu_pkg::*;

    logic [31:0] pc;
    logic        advance;

    assign advance   = !stall || is_valid_exc;  // Exception wins over stall
    assign imem_addr = pc;
    assign pcplus4   = pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_vector;
        end else if (advance) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ftod <= '0;
        end else if (is_valid_exc) begin
            ftod <= '0;  // Flush the slot fetched with the exception
        end else if (!stall) begin
            ftod.instr         <= imem_rdata;
            ftod.pc            <= pc;
            ftod.pcplus4       <= pcplus4;
            ftod.in_delay_slot <= in_delay_slot;  // Decode holds a branch or jump
            ftod.is_instr      <= 1'b1;
            ftod.addr_err_if   <= |pc[1:0];
        end
    end

    // First fetch after reset comes from the boot vector
    a_reset_vector: assert property (
        @(posedge clk) $rose(rst_n) |-> imem_addr == reset_vector
    );

endmodule

// ==== ctrl_decode.sv ====
`timescale 1ns/10ps

module ctrl_decode (
    input  cpu_pkg::instr_word instr,
    output cpu_pkg::ctrl_reg   dsig
);
    import cpu_pkg::*;

    always_comb begin
        dsig = '0;
        case (instr.r_fmt.op) inside
            op_special: begin
                case (instr.r_fmt.funct) inside
                    funct_jr: begin
                        dsig.isjump         = 1'b1;
                        dsig.jump[jump_reg] = 1'b1;
                        dsig.is_instr       = 1'b1;
                    end
                    funct_jalr: begin
                        dsig.isjump          = 1'b1;
                        dsig.jump[jump_reg]  = 1'b1;
                        dsig.jump[jump_link] = 1'b1;
                        dsig.regwrite        = 1'b1;
                        dsig.is_instr        = 1'b1;
                    end
                    6'b000000, 6'b000010, 6'b000011, 6'b000100, 6'b000110, 6'b000111,
                    [6'b100000:6'b100111], 6'b101010, 6'b101011: begin
                        dsig.regwrite = 1'b1;  // Shifts and ALU ops
                        dsig.is_instr = 1'b1;
                    end
                    default: dsig = '0;
                endcase
            end
            op_regimm: begin
                dsig.isbranch = 1'b1;
                dsig.is_instr = 1'b1;
                case (instr.i_fmt.rt)
                    rt_bltz: dsig.branch = br_bltz;
                    rt_bgez: dsig.branch = br_bgez;
                    rt_bltzal: begin
                        dsig.branch   = br_bltzal;
                        dsig.regwrite = 1'b1;
                    end
                    rt_bgezal: begin
                        dsig.branch   = br_bgezal;
                        dsig.regwrite = 1'b1;
                    end
                    default: dsig = '0;  // Unknown REGIMM form
                endcase
            end
            op_j, op_jal: begin
                dsig.isjump          = 1'b1;
                dsig.jump[jump_link] = instr.j_fmt.op == op_jal;
                dsig.regwrite        = instr.j_fmt.op == op_jal;
                dsig.is_instr        = 1'b1;
            end
            op_beq, op_bne, op_blez, op_bgtz: begin
                dsig.isbranch = 1'b1;
                dsig.is_instr = 1'b1;
                case (instr.i_fmt.op)
                    op_beq:  dsig.branch = br_beq;
                    op_bne:  dsig.branch = br_bne;
                    op_blez: dsig.branch = br_blez;
                    default: dsig.branch = br_bgtz;
                endcase
            end
            [op_addi:op_lui]: begin
                dsig.regwrite = 1'b1;
                dsig.is_instr = 1'b1;
            end
            op_cop0: begin
                if (instr.r_fmt.rs == cop0_co && instr.r_fmt.funct == funct_eret) begin
                    dsig.eret     = 1'b1;
                    dsig.is_instr = 1'b1;
                end
            end
            default: dsig = '0;
        endcase
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/10ps

module regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [31:0] wdata,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [0:31];

    // Same-cycle write is forwarded to the reader
    function automatic logic [31:0] read_port(input logic [4:0] ra);
        logic [31:0] val;
        if (ra == 5'd0) begin
            val = '0;
        end else if (we && waddr == ra) begin
            val = wdata;
        end else begin
            val = regs[ra];
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;  // $zero never written
        end
    end

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

endmodule

// ==== decode.sv ====
`timescale 1ns/10ps

module decode (
    input  cpu_pkg::dp_ftod  ftod,
    input  cpu_pkg::ctrl_reg dsig,
    input  logic [31:0]      rsdata,
    input  logic [31:0]      rtdata,
    input  logic [31:0]      f_pcplus4,
    input  logic [31:0]      cp0_epc,
    input  logic [31:0]      exc_addr,
    input  logic             is_valid_exc,
    output logic [31:0]      next_pc,
    output logic             f_indelayslot,
    output cpu_pkg::dp_dtoe  dtoe
);
    import cpu_pkg::*;

    branch_rel   rel;
    logic        cond;
    logic        taken;
    logic [31:0] sign_imm;
    logic [31:0] br_target;
    logic [31:0] j_target;

    assign rel.equal = rsdata == rtdata;
    assign rel.e0    = rsdata == 32'd0;
    assign rel.g0    = !rsdata[31] && !rel.e0;

    always_comb begin
        case (dsig.branch)
            br_beq:               cond = rel.equal;
            br_bne:               cond = !rel.equal;
            br_bgez, br_bgezal:   cond = rel.g0 || rel.e0;
            br_bgtz:              cond = rel.g0;
            br_blez:              cond = !rel.g0;
            br_bltz, br_bltzal:   cond = !rel.g0 && !rel.e0;
            default:              cond = 1'b0;
        endcase
    end

    assign taken     = dsig.isbranch && cond;
    assign sign_imm  = {{16{ftod.instr.i_fmt.imm[15]}}, ftod.instr.i_fmt.imm};
    assign br_target = ftod.pcplus4 + {sign_imm[29:0], 2'b00};  // Relative to the slot
    assign j_target  = {ftod.pcplus4[31:28], ftod.instr.j_fmt.index, 2'b00};

    always_comb begin
        if (is_valid_exc) begin
            next_pc = exc_addr;
        end else if (dsig.eret) begin
            next_pc = cp0_epc;
        end else if (dsig.isjump && dsig.jump[jump_reg]) begin
            next_pc = rsdata;
        end else if (dsig.isjump) begin
            next_pc = j_target;
        end else if (taken) begin
            next_pc = br_target;
        end else begin
            next_pc = f_pcplus4;  // Sequential fetch
        end
    end

    assign f_indelayslot = dsig.isbranch || dsig.isjump;

    assign dtoe.rs            = ftod.instr.r_fmt.rs;
    assign dtoe.rt            = ftod.instr.r_fmt.rt;
    assign dtoe.rd            = ftod.instr.r_fmt.rd;
    assign dtoe.sa            = ftod.instr.r_fmt.sa;
    assign dtoe.imm           = ftod.instr.i_fmt.imm;
    assign dtoe.cp0_sel       = ftod.instr.r_fmt.funct[2:0];
    assign dtoe.rsdata        = rsdata;
    assign dtoe.rtdata        = rtdata;
    assign dtoe.pc            = ftod.pc;
    assign dtoe.in_delay_slot = ftod.in_delay_slot;
    assign dtoe.addr_err_if   = ftod.addr_err_if;
    assign dtoe.is_instr      = ftod.is_instr;
    assign dtoe.ctrl          = dsig;

endmodule

// ==== decode_to_exec.sv ====
`timescale 1ns/10ps

module decode_to_exec (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  cpu_pkg::dp_dtoe d_in,
    output cpu_pkg::dp_dtoe dtoe
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dtoe <= '0;
        end else if (stall) begin
            dtoe <= '0;  // Bubble while decode holds its word
        end else begin
            dtoe <= d_in;
        end
    end

    // No valid slot leaves decode on a stalled edge
    a_stall_bubble: assert property (
        @(posedge clk) disable iff (!rst_n) stall |=> !dtoe.is_instr
    );

    // A valid slot is handed on one edge after decode saw it
    a_slot_handoff: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!stall && d_in.is_instr) |=> (dtoe.is_instr && dtoe.pc == $past(d_in.pc))
    );

endmodule

// ==== cpu_frontend.sv ====
`timescale 1ns/10ps

module cpu_frontend (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    output logic [31:0]        imem_addr,
    input  cpu_pkg::instr_word imem_rdata,
    input  logic               wb_we,
    input  logic [4:0]         wb_addr,
    input  logic [31:0]        wb_data,
    input  logic [31:0]        cp0_epc,
    input  logic [31:0]        exc_addr,
    input  logic               is_valid_exc,
    output cpu_pkg::dp_dtoe    dtoe
);
    import cpu_pkg::*;

    dp_ftod      ftod;
    ctrl_reg     dsig;
    dp_dtoe      d_dtoe;
    logic [31:0] next_pc;
    logic [31:0] f_pcplus4;
    logic [31:0] rsdata;
    logic [31:0] rtdata;
    logic        in_delay_slot;

    pc_fetch pc_fetch_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .is_valid_exc  (is_valid_exc),
        .next_pc       (next_pc),
        .imem_rdata    (imem_rdata),
        .in_delay_slot (in_delay_slot),
        .imem_addr     (imem_addr),
        .pcplus4       (f_pcplus4),
        .ftod          (ftod)
    );

    ctrl_decode ctrl_decode_inst (
        .instr (ftod.instr),
        .dsig  (dsig)
    );

    regfile regfile_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (wb_we),
        .waddr (wb_addr),
        .ra1   (ftod.instr.r_fmt.rs),
        .ra2   (ftod.instr.r_fmt.rt),
        .wdata (wb_data),
        .rd1   (rsdata),
        .rd2   (rtdata)
    );

    decode decode_inst (
        .ftod          (ftod),
        .dsig          (dsig),
        .rsdata        (rsdata),
        .rtdata        (rtdata),
        .f_pcplus4     (f_pcplus4),
        .cp0_epc       (cp0_epc),
        .exc_addr      (exc_addr),
        .is_valid_exc  (is_valid_exc),
        .next_pc       (next_pc),
        .f_indelayslot (in_delay_slot),
        .dtoe          (d_dtoe)
    );

    decode_to_exec decode_to_exec_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .d_in  (d_dtoe),
        .dtoe  (dtoe)
    );

endmodule

// ==== tb_cpu_frontend.sv ====
`timescale 1ns/10ps

module tb_cpu_frontend;
    import cpu_pkg::*;

    typedef enum logic [2:0] {alu_row, branch_row, jump_row, jreg_row, eret_row, exc_row} row_kind;

    typedef struct packed {
        row_kind     kind;
        logic [31:0] word;
        logic [31:0] rs_val;  // Preloaded into $8
        logic [31:0] rt_val;  // Written to $9 while the row decodes
        logic        taken;
        logic [31:0] target;  // Absolute target of jr, eret and exception rows
    } test_row;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic [31:0] imem_addr;
    instr_word   imem_rdata;
    logic        wb_we;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic [31:0] cp0_epc;
    logic [31:0] exc_addr;
    logic        is_valid_exc;
    dp_dtoe      dtoe;
    logic        rom_armed;
    logic [31:0] rom_addr;
    instr_word   rom_word;
    test_row     rows[$];
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    cpu_frontend cpu_frontend_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .wb_we        (wb_we),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .cp0_epc      (cp0_epc),
        .exc_addr     (exc_addr),
        .is_valid_exc (is_valid_exc),
        .dtoe         (dtoe)
    );

    always #50 clk = ~clk;

    // ROM model returns a zero word (sll $0) everywhere but the armed row
    assign imem_rdata = (rom_armed && imem_addr == rom_addr) ? rom_word : '0;

    function automatic logic [31:0] imm_word(input logic [5:0] op, input logic [4:0] rt,
                                             input logic [15:0] imm);
        return {op, 5'd8, rt, imm};
    endfunction

    function automatic logic [31:0] expected_next(input test_row r, input logic [31:0] a);
        logic [31:0] slot;
        logic [31:0] next;
        slot = a + 32'd4;
        case (r.kind)
            alu_row:    next = slot + 32'd4;
            branch_row: next = r.taken ? slot + {{14{r.word[15]}}, r.word[15:0], 2'b00}
                                       : slot + 32'd4;
            jump_row:   next = {slot[31:28], r.word[25:0], 2'b00};
            default:    next = r.target;
        endcase
        return next;
    endfunction

    function automatic dp_dtoe nop_dtoe(input logic [31:0] pc, input logic in_slot,
                                        input logic valid);
        dp_dtoe d;
        d               = '0;
        d.pc            = pc;
        d.in_delay_slot = in_slot;
        d.is_instr      = valid;
        d.ctrl.regwrite = 1'b1;  // sll writes rd
        d.ctrl.is_instr = 1'b1;
        return d;
    endfunction

    function automatic dp_dtoe alu_dtoe(input test_row r, input logic [31:0] pc);
        dp_dtoe d;
        d               = nop_dtoe(pc, 1'b0, 1'b1);
        d.rs            = r.word[25:21];
        d.rt            = r.word[20:16];
        d.rd            = r.word[15:11];
        d.sa            = r.word[10:6];
        d.imm           = r.word[15:0];
        d.cp0_sel       = r.word[2:0];
        d.rsdata        = r.rs_val;
        d.rtdata        = r.rt_val;
        return d;
    endfunction

    task automatic check_addr(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_dtoe(input dp_dtoe got, input dp_dtoe exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors != start_errors) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, (errors == start_errors) ? "ok" : "failed");
    endtask

    task automatic add_row(input row_kind kind, input logic [31:0] word, input logic [31:0] rs_val,
                           input logic [31:0] rt_val, input logic taken, input logic [31:0] target);
        test_row r;
        r.kind   = kind;
        r.word   = word;
        r.rs_val = rs_val;
        r.rt_val = rt_val;
        r.taken  = taken;
        r.target = target;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] eret_word;
        eret_word = {6'h10, 5'h10, 15'd0, 6'h18};
        add_row(alu_row, {6'h00, 5'd8, 5'd9, 5'd10, 5'd0, 6'h21}, $urandom, $urandom, 1'b0, 32'd0);
        add_row(alu_row, {6'h00, 5'd8, 5'd9, 5'd12, 5'd0, 6'h2a}, $urandom, $urandom, 1'b0, 32'd0);
        add_row(branch_row, imm_word(6'h04, 5'd9, 16'h0020), 32'd5, 32'd5, 1'b1, 32'd0);  // beq
        add_row(branch_row, imm_word(6'h04, 5'd9, 16'h0020), 32'd5, 32'd6, 1'b0, 32'd0);
        add_row(branch_row, imm_word(6'h05, 5'd9, 16'hfff8), 32'd5, 32'd6, 1'b1, 32'd0);  // bne
        add_row(branch_row, imm_word(6'h05, 5'd9, 16'hfff8), 32'hfffffffd, 32'hfffffffd, 1'b0, 32'd0);
        add_row(branch_row, imm_word(6'h01, 5'd1, 16'h0010), 32'd0, 32'd0, 1'b1, 32'd0);  // bgez
        add_row(branch_row, imm_word(6'h01, 5'd1, 16'h0010), 32'hffffffff, 32'd0, 1'b0, 32'd0);
        add_row(branch_row, imm_word(6'h07, 5'd0, 16'hfffc), 32'd7, 32'd0, 1'b1, 32'd0);  // bgtz
        add_row(branch_row, imm_word(6'h07, 5'd0, 16'hfffc), 32'd0, 32'd0, 1'b0, 32'd0);
        add_row(branch_row, imm_word(6'h06, 5'd0, 16'h0040), 32'd0, 32'd0, 1'b1, 32'd0);  // blez
        add_row(branch_row, imm_word(6'h06, 5'd0, 16'h0040), 32'h80000000, 32'd0, 1'b1, 32'd0);
        add_row(branch_row, imm_word(6'h06, 5'd0, 16'h0040), 32'd1, 32'd0, 1'b0, 32'd0);
        add_row(branch_row, imm_word(6'h01, 5'd0, 16'hffe0), 32'hfffffff0, 32'd0, 1'b1, 32'd0);  // bltz
        add_row(branch_row, imm_word(6'h01, 5'd0, 16'hffe0), 32'd0, 32'd0, 1'b0, 32'd0);
        add_row(branch_row, imm_word(6'h01, 5'd17, 16'h0008), 32'd3, 32'd0, 1'b1, 32'd0);  // bgezal
        add_row(branch_row, imm_word(6'h01, 5'd17, 16'h0008), 32'hfffffffe, 32'd0, 1'b0, 32'd0);
        add_row(branch_row, imm_word(6'h01, 5'd16, 16'h0100), 32'h80000000, 32'd0, 1'b1, 32'd0);
        add_row(branch_row, imm_word(6'h01, 5'd16, 16'h0100), 32'd1, 32'd0, 1'b0, 32'd0);  // bltzal
        add_row(jump_row, {6'h02, 26'h0123456}, 32'd0, 32'd0, 1'b1, 32'd0);
        add_row(jreg_row, {6'h00, 5'd8, 15'd0, 6'h08}, 32'h00401000, 32'd0, 1'b1, 32'h00401000);
        add_row(eret_row, eret_word, 32'd0, 32'd0, 1'b1, cp0_epc);
        add_row(exc_row, eret_word, 32'd0, 32'd0, 1'b1, exc_addr);  // Exception beats eret
    endtask

    task automatic run_row(input test_row r);
        logic [31:0] a;
        int          start_errors;
        int          n;
        start_errors = errors;
        @(negedge clk);
        a         = imem_addr + 32'd12;
        rom_addr  = a;
        rom_word  = r.word;
        rom_armed = 1'b1;
        wb_we     = 1'b1;
        wb_addr   = 5'd8;
        wb_data   = r.rs_val;
        @(negedge clk);
        wb_we = 1'b0;
        n     = 0;
        while (imem_addr != a && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (imem_addr != a) begin
            timed_out = 1'b1;
            $display("test %0d: fetch never reached address %h", tests_run + 1, a);
        end else begin
            @(negedge clk);  // Row in decode and slot in fetch
            rom_armed    = 1'b0;
            wb_we        = 1'b1;
            wb_addr      = 5'd9;
            wb_data      = r.rt_val;
            is_valid_exc = r.kind == exc_row;
            @(negedge clk);
            wb_we        = 1'b0;
            is_valid_exc = 1'b0;
            check_addr(imem_addr, expected_next(r, a), "next fetch");
            if (r.kind == alu_row) begin
                check_dtoe(dtoe, alu_dtoe(r, a), "decoded word");
            end
            @(negedge clk);
            if (r.kind == exc_row) begin
                check_dtoe(dtoe, nop_dtoe(32'd0, 1'b0, 1'b0), "flushed slot");
            end else begin
                check_dtoe(dtoe, nop_dtoe(a + 32'd4, r.kind inside {branch_row, jump_row, jreg_row},
                                          1'b1), "delay slot");
            end
            report_test(r.kind.name(), start_errors);
        end
    endtask

    task automatic check_reset_fetch();
        int start_errors;
        start_errors = errors;
        for (int i = 0; i < 4; i++) begin
            check_addr(imem_addr, reset_vector + 32'(4 * i), "sequential fetch");
            @(negedge clk);
        end
        report_test("reset", start_errors);
    endtask

    task automatic check_stall();
        logic [31:0] held;
        int          start_errors;
        start_errors = errors;
        @(negedge clk);
        stall = 1'b1;
        held  = imem_addr;
        repeat (3) begin
            @(negedge clk);
            check_addr(imem_addr, held, "fetch under stall");
            check_dtoe(dtoe, '0, "bubble under stall");
        end
        stall = 1'b0;
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            check_addr(imem_addr, held + 32'(4 * (i + 1)), "fetch after stall");
            check_dtoe(dtoe, nop_dtoe(held - 32'd4 + 32'(4 * i), 1'b0, 1'b1), "resumed slot");
        end
        report_test("stall", start_errors);
    endtask

    initial begin
        void'($urandom(32'hdbccb73d));
        clk          = 1'b0;
        rst_n        = 1'b0;
        stall        = 1'b0;
        wb_we        = 1'b0;
        wb_addr      = 5'd0;
        wb_data      = 32'd0;
        cp0_epc      = 32'h80000200;
        exc_addr     = 32'hbfc00380;
        is_valid_exc = 1'b0;
        rom_armed    = 1'b0;
        rom_addr     = 32'd0;
        rom_word     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        build_table();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_reset_fetch();
        foreach (rows[i]) begin
            if (!timed_out) begin
                run_row(rows[i]);
            end
        end
        if (!timed_out) begin
            repeat (3) @(negedge clk);
            check_stall();
        end
        $display("tests: %0d run, %0d failed, %0d checks failed", tests_run, tests_failed, errors);
        if (timed_out) begin
            $display("run stopped early because a fetch address was never reached");
            $display("STATUS: FAIL");
        end else if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
cpu_pkg.sv
pc_fetch.sv
ctrl_decode.sv
regfile.sv
decode.sv
decode_to_exec.sv
cpu_frontend.sv
tb_cpu_frontend.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the front-end testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -f sources.f --top-module tb_cpu_frontend -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_cpu_frontend 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" <<< "$output"; then
    exit 0
fi
exit 1
